// ==== cache_pkg.sv ====
// shared types for the 2-way cache; tag is fixed at 5 bits, index width is a module parameter

package cache_pkg;

   // datapath widths
   typedef logic [15:0] word_t;
   typedef logic [15:0] addr_t;

   localparam int TAG_W          = 5;
   localparam int OFS_W          = 3;
   localparam int WORDS_PER_LINE = 4;

   // processor opcodes
   typedef enum logic {
      OP_RD = 1'b0,
      OP_WR = 1'b1
   } op_e;

   // processor request, 33 bits
   typedef struct packed {
      op_e   op;
      addr_t addr;
      word_t wdata;
   } cpu_req_t;

   // processor response, 18 bits
   typedef struct packed {
      word_t rdata;
      logic  hit;
      logic  err;
   } cpu_rsp_t;

   // memory port, 34 bits
   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      word_t wdata;
   } mem_req_t;

   // controller states
   typedef enum logic [3:0] {
      IDLE,
      COMPARE,
      WB_REQ,
      WB_WAIT,
      FILL_REQ,
      FILL_WAIT,
      FILL_DONE,
      RESPOND,
      ERR_RESP
   } ctrl_state_e;

   // controls shared by both ways
   typedef struct packed {
      logic             comp;
      logic             write;
      logic             valid_in;
      logic [OFS_W-1:0] offset;
      // 0 processor word, 1 memory word
      logic             data_sel;
      // 0 request offset, 1 controller offset
      logic             ofs_sel;
   } way_ctrl_t;

   // status returned by each way
   typedef struct packed {
      logic             hit;
      logic             valid;
      logic             dirty;
      logic [TAG_W-1:0] tag;
      word_t            rdata;
   } way_stat_t;

endpackage

// ==== cache_way.sv ====
// one way of 2^INDEX_W lines x 4 words; only valid bits reset, tag/dirty/data come up unknown
`timescale 1ns/10ps

module cache_way
   import cache_pkg::*;
#(
   parameter int INDEX_W = 8
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                enable,
   input  logic                wr_en,
   input  way_ctrl_t           ctrl,
   input  logic [TAG_W-1:0]    tag_in,
   input  logic [INDEX_W-1:0]  index,
   input  logic [OFS_W-1:0]    offset,
   input  word_t               wdata,
   output way_stat_t           stat
);

   localparam int LINES = 1 << INDEX_W;

   logic [TAG_W-1:0] tag_arr   [LINES];
   logic             dirty_arr [LINES];
   word_t            data_arr  [LINES*WORDS_PER_LINE];
   logic [LINES-1:0] valid_arr;

   logic [OFS_W-1:0]   ofs;
   logic [INDEX_W+1:0] waddr;
   logic               tag_eq;
   logic               do_wr;

   // controller offset overrides the request offset during fills and write-back
   assign ofs   = ctrl.ofs_sel ? ctrl.offset : offset;
   assign waddr = {index, ofs[2:1]};

   assign tag_eq = (tag_arr[index] == tag_in);

   // status straight from the arrays
   assign stat.hit   = enable & ctrl.comp & tag_eq;
   assign stat.valid = enable & valid_arr[index];
   assign stat.dirty = enable & dirty_arr[index];
   assign stat.tag   = tag_arr[index];
   assign stat.rdata = enable ? data_arr[waddr] : '0;

   // compare writes land only on a valid hit
   assign do_wr = enable & wr_en & (~ctrl.comp | (tag_eq & valid_arr[index]));

   always_ff @(posedge clk) begin
      if (do_wr) begin
         data_arr[waddr] <= wdata;
         if (ctrl.comp) begin
            dirty_arr[index] <= 1'b1;
         end else begin
            // access mode installs the line clean
            tag_arr[index]   <= tag_in;
            dirty_arr[index] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_arr <= '0;
      end else if (do_wr && !ctrl.comp) begin
         valid_arr[index] <= ctrl.valid_in;
      end
   end

endmodule

// ==== way_select.sv ====
// way choice and muxing for two ways; address bits above the tag are ignored when INDEX_W < 8
`timescale 1ns/10ps

module way_select
   import cache_pkg::*;
#(
   parameter int INDEX_W = 8
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             flip,
   input  logic             enable_all,
   input  addr_t            req_addr,
   input  way_ctrl_t        ctrl,
   input  logic [OFS_W-1:0] mem_ofs,
   input  logic             tag_src,
   input  way_stat_t        stat0,
   input  way_stat_t        stat1,
   output logic             en0,
   output logic             en1,
   output logic             wr0,
   output logic             wr1,
   output way_stat_t        sel_stat,
   output word_t            rdata,
   output addr_t            mem_addr
);

   localparam int LINE_W = TAG_W + INDEX_W;

   logic        victim;
   logic        victim_nxt;
   logic        choose;
   logic        way_q;
   logic        sel;
   logic [4:0]  wb_tag;
   logic [LINE_W-1:0] line_addr;

   // victim after this access's flip
   assign victim_nxt = victim ^ flip;

   // hit first, then invalid way, then victim
   always_comb begin
      if (stat0.hit && stat0.valid) begin
         choose = 1'b0;
      end else if (stat1.hit && stat1.valid) begin
         choose = 1'b1;
      end else if (!stat0.valid) begin
         choose = 1'b0;
      end else if (!stat1.valid) begin
         choose = 1'b1;
      end else begin
         choose = victim_nxt;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         victim <= 1'b0;
         way_q  <= 1'b0;
      end else begin
         victim <= victim_nxt;
         // registered at the compare edge
         if (flip) begin
            way_q <= choose;
         end
      end
   end

   // live choice during compare, registered way afterwards
   assign sel = enable_all ? choose : way_q;

   assign en0 = enable_all | ~way_q;
   assign en1 = enable_all | way_q;
   assign wr0 = ctrl.write & ~sel;
   assign wr1 = ctrl.write & sel;

   assign sel_stat = sel ? stat1 : stat0;
   assign rdata    = way_q ? stat1.rdata : stat0.rdata;

   // write-back uses the stored tag, fill uses the request tag
   assign wb_tag    = way_q ? stat1.tag : stat0.tag;
   assign line_addr = tag_src ? {wb_tag, req_addr[INDEX_W+2:3]}
                              : req_addr[LINE_W+2:3];
   assign mem_addr  = addr_t'({line_addr, mem_ofs});

endmodule

// ==== banked_mem.sv ====
// behavioural 4-bank word memory, zero at start; bank busy 4 cycles, needs MEM_LAT between 1 and 3
`timescale 1ns/10ps

module banked_mem
   import cache_pkg::*;
#(
   parameter int INDEX_W = 8,
   parameter int MEM_LAT = 2
) (
   input  logic     clk,
   input  logic     arst_n,
   input  mem_req_t req,
   output logic     stall,
   output word_t    rdata,
   output logic     rvalid
);

   localparam int AW       = TAG_W + INDEX_W + 2;
   localparam int DEPTH    = 1 << AW;
   localparam int BUSY_CYC = 4;

   word_t         store [DEPTH];
   logic [2:0]    busy  [4];
   word_t         dpipe [MEM_LAT];
   logic [MEM_LAT-1:0] vpipe;

   logic [AW-1:0] waddr;
   logic [1:0]    bank;
   logic          access;
   logic          rd_acc;
   logic          wr_acc;

   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         store[i] = '0;
      end
   end

   // word address, bank from word offset
   assign waddr = req.addr[AW:1];
   assign bank  = req.addr[2:1];

   assign access = req.rd | req.wr;
   assign stall  = access & (busy[bank] != 3'd0);
   assign rd_acc = req.rd & ~stall;
   assign wr_acc = req.wr & ~stall;

   // per-bank busy counters
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < 4; b++) begin
            busy[b] <= 3'd0;
         end
      end else begin
         for (int b = 0; b < 4; b++) begin
            if ((rd_acc || wr_acc) && bank == 2'(b)) begin
               busy[b] <= 3'(BUSY_CYC);
            end else if (busy[b] != 3'd0) begin
               busy[b] <= busy[b] - 3'd1;
            end
         end
      end
   end

   // store write and read data pipeline
   always_ff @(posedge clk) begin
      if (wr_acc) begin
         store[waddr] <= req.wdata;
      end
      dpipe[0] <= store[waddr];
      for (int i = 1; i < MEM_LAT; i++) begin
         dpipe[i] <= dpipe[i-1];
      end
   end

   // read valid pipeline, several beats in flight
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vpipe <= '0;
      end else begin
         vpipe[0] <= rd_acc;
         for (int i = 1; i < MEM_LAT; i++) begin
            vpipe[i] <= vpipe[i-1];
         end
      end
   end

   assign rdata  = dpipe[MEM_LAT-1];
   assign rvalid = vpipe[MEM_LAT-1];

endmodule

// ==== cache_ctrl.sv ====
// cache FSM, one request at a time; mem_req addr/wdata carry the latched request toward the ways
`timescale 1ns/10ps

module cache_ctrl
   import cache_pkg::*;
(
   input  logic             clk,
   input  logic             arst_n,
   input  logic             req_valid,
   input  cpu_req_t         req,
   output logic             req_ready,
   output logic             rsp_valid,
   output logic             rsp_hit,
   output logic             rsp_err,
   input  way_stat_t        sel_stat,
   input  logic             mem_stall,
   input  logic             mem_rvalid,
   input  word_t            mem_rdata,
   output way_ctrl_t        way_ctrl,
   output mem_req_t         mem_req,
   output logic [OFS_W-1:0] mem_ofs,
   output logic             tag_src,
   output logic             flip,
   output logic             enable_all
);

   ctrl_state_e state;
   ctrl_state_e state_nxt;

   cpu_req_t req_q;
   logic     hit_q;
   logic [1:0] cnt;
   logic [1:0] rcnt;
   logic     fill_wr;

   // a returning fill beat
   assign fill_wr = mem_rvalid & ((state == FILL_REQ) | (state == FILL_WAIT));

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (req_valid) begin
               state_nxt = req.addr[0] ? ERR_RESP : COMPARE;
            end
         end
         COMPARE: begin
            if (sel_stat.hit && sel_stat.valid) begin
               state_nxt = RESPOND;
            end else if (sel_stat.valid && sel_stat.dirty) begin
               state_nxt = WB_REQ;
            end else begin
               state_nxt = FILL_REQ;
            end
         end
         WB_REQ: begin
            if (!mem_stall && cnt == 2'd3) begin
               state_nxt = WB_WAIT;
            end
         end
         // one turnaround cycle, fill stalls on busy banks anyway
         WB_WAIT: state_nxt = FILL_REQ;
         FILL_REQ: begin
            if (!mem_stall && cnt == 2'd3) begin
               state_nxt = FILL_WAIT;
            end
         end
         FILL_WAIT: begin
            if (mem_rvalid && rcnt == 2'd3) begin
               state_nxt = FILL_DONE;
            end
         end
         FILL_DONE: state_nxt = RESPOND;
         RESPOND:   state_nxt = IDLE;
         ERR_RESP:  state_nxt = IDLE;
         default:   state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
         hit_q <= 1'b0;
         cnt   <= 2'd0;
         rcnt  <= 2'd0;
      end else begin
         state <= state_nxt;
         if (state == COMPARE) begin
            hit_q <= sel_stat.hit & sel_stat.valid;
            cnt   <= 2'd0;
            rcnt  <= 2'd0;
         end
         // issue counter, wraps to 0 after the fourth beat
         if ((state == WB_REQ || state == FILL_REQ) && !mem_stall) begin
            cnt <= cnt + 2'd1;
         end
         // fill words counted by arrival
         if (fill_wr) begin
            rcnt <= rcnt + 2'd1;
         end
      end
   end

   // request latch, payload only
   always_ff @(posedge clk) begin
      if (state == IDLE && req_valid) begin
         req_q <= req;
      end
   end

   assign req_ready = (state == IDLE);
   assign rsp_valid = (state == RESPOND) | (state == ERR_RESP);
   assign rsp_hit   = (state == RESPOND) & hit_q;
   assign rsp_err   = (state == ERR_RESP);

   assign flip       = (state == COMPARE);
   assign enable_all = (state == COMPARE);
   assign tag_src    = (state == WB_REQ);
   assign mem_ofs    = {cnt, 1'b0};

   always_comb begin
      way_ctrl          = '0;
      way_ctrl.valid_in = 1'b1;
      case (state)
         COMPARE, FILL_DONE: begin
            way_ctrl.comp  = 1'b1;
            way_ctrl.write = (req_q.op == OP_WR);
         end
         // read the victim beat at the issue offset
         WB_REQ: begin
            way_ctrl.ofs_sel = 1'b1;
            way_ctrl.offset  = {cnt, 1'b0};
         end
         FILL_REQ, FILL_WAIT: begin
            way_ctrl.write    = fill_wr;
            way_ctrl.data_sel = 1'b1;
            way_ctrl.ofs_sel  = 1'b1;
            way_ctrl.offset   = {rcnt, 1'b0};
         end
         default: begin
            way_ctrl.comp = 1'b0;
         end
      endcase
   end

   // addr is the latched request, way_select forms the real memory address
   assign mem_req.rd    = (state == FILL_REQ);
   assign mem_req.wr    = (state == WB_REQ);
   assign mem_req.addr  = req_q.addr;
   // word written into the ways
   assign mem_req.wdata = way_ctrl.data_sel ? mem_rdata : req_q.wdata;

endmodule

// ==== mem_system.sv ====
// top of the cache; processor holds req until req_ready, one request outstanding at a time
`timescale 1ns/10ps

module mem_system
   import cache_pkg::*;
#(
   parameter int INDEX_W = 8,
   parameter int MEM_LAT = 2
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     req_valid,
   input  cpu_req_t req,
   output logic     req_ready,
   output logic     rsp_valid,
   output cpu_rsp_t rsp
);

   way_ctrl_t        way_ctrl;
   way_stat_t        stat0;
   way_stat_t        stat1;
   way_stat_t        sel_stat;
   mem_req_t         ctrl_mem_req;
   mem_req_t         mem_req;
   logic [OFS_W-1:0] mem_ofs;
   logic             tag_src;
   logic             flip;
   logic             enable_all;
   logic             en0;
   logic             en1;
   logic             wr0;
   logic             wr1;
   logic             rsp_hit;
   logic             rsp_err;
   logic             mem_stall;
   logic             mem_rvalid;
   word_t            mem_rdata;
   word_t            way_rdata;
   addr_t            mem_addr;

   // latched request fields for both ways
   cache_way #(.INDEX_W(INDEX_W)) u_way0 (
      .clk    (clk),
      .arst_n (arst_n),
      .enable (en0),
      .wr_en  (wr0),
      .ctrl   (way_ctrl),
      .tag_in (ctrl_mem_req.addr[INDEX_W+7:INDEX_W+3]),
      .index  (ctrl_mem_req.addr[INDEX_W+2:3]),
      .offset (ctrl_mem_req.addr[2:0]),
      .wdata  (ctrl_mem_req.wdata),
      .stat   (stat0)
   );

   cache_way #(.INDEX_W(INDEX_W)) u_way1 (
      .clk    (clk),
      .arst_n (arst_n),
      .enable (en1),
      .wr_en  (wr1),
      .ctrl   (way_ctrl),
      .tag_in (ctrl_mem_req.addr[INDEX_W+7:INDEX_W+3]),
      .index  (ctrl_mem_req.addr[INDEX_W+2:3]),
      .offset (ctrl_mem_req.addr[2:0]),
      .wdata  (ctrl_mem_req.wdata),
      .stat   (stat1)
   );

   way_select #(.INDEX_W(INDEX_W)) u_way_select (
      .clk        (clk),
      .arst_n     (arst_n),
      .flip       (flip),
      .enable_all (enable_all),
      .req_addr   (ctrl_mem_req.addr),
      .ctrl       (way_ctrl),
      .mem_ofs    (mem_ofs),
      .tag_src    (tag_src),
      .stat0      (stat0),
      .stat1      (stat1),
      .en0        (en0),
      .en1        (en1),
      .wr0        (wr0),
      .wr1        (wr1),
      .sel_stat   (sel_stat),
      .rdata      (way_rdata),
      .mem_addr   (mem_addr)
   );

   cache_ctrl u_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .rsp_valid  (rsp_valid),
      .rsp_hit    (rsp_hit),
      .rsp_err    (rsp_err),
      .sel_stat   (sel_stat),
      .mem_stall  (mem_stall),
      .mem_rvalid (mem_rvalid),
      .mem_rdata  (mem_rdata),
      .way_ctrl   (way_ctrl),
      .mem_req    (ctrl_mem_req),
      .mem_ofs    (mem_ofs),
      .tag_src    (tag_src),
      .flip       (flip),
      .enable_all (enable_all)
   );

   // write-back data is the selected way's word
   assign mem_req = '{rd: ctrl_mem_req.rd, wr: ctrl_mem_req.wr,
                      addr: mem_addr, wdata: way_rdata};

   banked_mem #(.INDEX_W(INDEX_W), .MEM_LAT(MEM_LAT)) u_mem (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (mem_req),
      .stall  (mem_stall),
      .rdata  (mem_rdata),
      .rvalid (mem_rvalid)
   );

   assign rsp = '{rdata: way_rdata, hit: rsp_hit, err: rsp_err};

endmodule

// ==== mem_system_chk.sv ====
// handshake and memory-port checks, bound into mem_system; assumes one request in flight
`timescale 1ns/10ps

module mem_system_chk
   import cache_pkg::*;
(
   input logic     clk,
   input logic     arst_n,
   input logic     req_valid,
   input logic     req_ready,
   input logic     rsp_valid,
   input cpu_rsp_t rsp,
   input mem_req_t mem_req,
   input logic     mem_stall
);

   // set from acceptance until the response
   logic pending;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= 1'b0;
      end else if (req_valid && req_ready) begin
         pending <= 1'b1;
      end else if (rsp_valid) begin
         pending <= 1'b0;
      end
   end

   a_rsp_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      rsp_valid |=> !rsp_valid)
      else $error("rsp_valid high for more than one cycle");

   a_busy_not_ready: assert property (@(posedge clk) disable iff (!arst_n)
      pending |-> !req_ready)
      else $error("req_ready high while a request is outstanding");

   a_rsp_has_req: assert property (@(posedge clk) disable iff (!arst_n)
      rsp_valid |-> pending)
      else $error("response without an accepted request");

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(mem_req.rd && mem_req.wr))
      else $error("memory rd and wr both high");

   a_err_valid: assert property (@(posedge clk) disable iff (!arst_n)
      rsp.err |-> rsp_valid)
      else $error("err flag outside a response");

   // stalled access is retried unchanged
   a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (mem_req.rd || mem_req.wr) && mem_stall |=>
         $stable(mem_req.rd) && $stable(mem_req.wr) && $stable(mem_req.addr))
      else $error("memory request changed under stall");

   a_stall_wdata: assert property (@(posedge clk) disable iff (!arst_n)
      mem_req.wr && mem_stall |=> $stable(mem_req.wdata))
      else $error("write data changed under stall");

endmodule

bind mem_system mem_system_chk u_chk (
   .clk       (clk),
   .arst_n    (arst_n),
   .req_valid (req_valid),
   .req_ready (req_ready),
   .rsp_valid (rsp_valid),
   .rsp       (rsp),
   .mem_req   (mem_req),
   .mem_stall (mem_stall)
);

// ==== mem_system_tb.sv ====
// self-checking testbench for mem_system at INDEX_W 8; the first mismatch stops the run
`timescale 1ns/10ps

module mem_system_tb
   import cache_pkg::*;
();

   localparam int INDEX_W    = 8;
   localparam int MEM_LAT    = 2;
   localparam int LINES      = 1 << INDEX_W;
   localparam int MEM_WORDS  = 1 << 15;
   localparam int CLK_PERIOD = 8;
   localparam int N_RAND     = 300;
   localparam int N_REQ      = N_RAND + 32;

   // expected response, queued at acceptance
   typedef struct packed {
      logic        is_rd;
      logic        hit;
      logic        err;
      word_t       rdata;
      logic [31:0] t_acc;
   } exp_t;

   logic     clk;
   logic     arst_n;
   logic     req_valid;
   cpu_req_t req;
   logic     req_ready;
   logic     rsp_valid;
   cpu_rsp_t rsp;

   // reference model of tags, victim bit and memory as the processor sees it
   logic [TAG_W-1:0] tag_m   [2][LINES];
   logic             valid_m [2][LINES];
   logic             victim_m;
   word_t            mem_m   [MEM_WORDS];

   exp_t        exp_q [$];
   exp_t        cur;
   logic [31:0] cyc;
   logic [31:0] lat_exp;
   logic [31:0] rnd;
   int          seed;

   mem_system #(.INDEX_W(INDEX_W), .MEM_LAT(MEM_LAT)) u_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // cycle count for latency checks
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cyc <= '0;
      end else begin
         cyc <= cyc + 32'd1;
      end
   end

   task automatic stop_with_error(input string line);
      $display("%s", line);
      $display("Test failures found");
      $fatal(1);
   endtask

   // byte address from tag, index and word number
   function automatic addr_t make_addr(input int tg, input int ix, input int wd);
      logic [TAG_W-1:0]   t;
      logic [INDEX_W-1:0] i;
      logic [1:0]         w;
      t = tg[TAG_W-1:0];
      i = ix[INDEX_W-1:0];
      w = wd[1:0];
      return {t, i, w, 1'b0};
   endfunction

   // model update at acceptance: hit way first, then invalid way, then victim
   task automatic model_access(input cpu_req_t r);
      exp_t               e;
      logic [INDEX_W-1:0] idx;
      logic [TAG_W-1:0]   tg;
      logic               w;
      e       = '0;
      e.is_rd = (r.op == OP_RD);
      e.t_acc = cyc;
      idx     = r.addr[INDEX_W+2:3];
      tg      = r.addr[INDEX_W+7:INDEX_W+3];
      if (r.addr[0]) begin
         // odd address leaves everything alone
         e.err = 1'b1;
      end else begin
         victim_m = ~victim_m;
         if ((valid_m[0][idx] && tag_m[0][idx] == tg) ||
             (valid_m[1][idx] && tag_m[1][idx] == tg)) begin
            e.hit = 1'b1;
         end else begin
            if (!valid_m[0][idx]) begin
               w = 1'b0;
            end else if (!valid_m[1][idx]) begin
               w = 1'b1;
            end else begin
               w = victim_m;
            end
            tag_m[w][idx]   = tg;
            valid_m[w][idx] = 1'b1;
         end
         if (r.op == OP_WR) begin
            mem_m[r.addr[15:1]] = r.wdata;
         end
         e.rdata = mem_m[r.addr[15:1]];
      end
      exp_q.push_back(e);
   endtask

   // present a request and hold it until the DUT takes it
   task automatic send_req(input op_e op, input addr_t addr, input word_t wdata);
      cpu_req_t r;
      r.op      = op;
      r.addr    = addr;
      r.wdata   = wdata;
      req_valid <= 1'b1;
      req       <= r;
      do begin
         @(posedge clk);
      end while (!req_ready);
      model_access(r);
   endtask

   task automatic idle(input int n);
      req_valid <= 1'b0;
      repeat (n) @(posedge clk);
   endtask

   // response checks against the queued expectation
   always @(posedge clk) begin
      if (arst_n && rsp_valid) begin
         assert (exp_q.size() != 0)
            else stop_with_error("a response arrived with no request outstanding");
         cur = exp_q.pop_front();
         assert (rsp.err == cur.err)
            else stop_with_error($sformatf("ERR t=%0t rsp.err got %b exp %b",
                                           $time, rsp.err, cur.err));
         assert (rsp.hit == cur.hit)
            else stop_with_error($sformatf("ERR t=%0t rsp.hit got %b exp %b",
                                           $time, rsp.hit, cur.hit));
         if (cur.is_rd && !cur.err) begin
            assert (rsp.rdata == cur.rdata)
               else stop_with_error($sformatf("ERR t=%0t rsp.rdata got %h exp %h",
                                              $time, rsp.rdata, cur.rdata));
         end
         // fixed latency only for hits and errors
         if (cur.hit || cur.err) begin
            lat_exp = cur.err ? 32'd1 : 32'd2;
            assert (cyc - cur.t_acc == lat_exp)
               else stop_with_error($sformatf("ERR t=%0t rsp latency got %0d exp %0d",
                                              $time, cyc - cur.t_acc, lat_exp));
         end
      end
   end

   initial begin
      seed      = 20614;
      arst_n    = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      victim_m  = 1'b0;
      for (int i = 0; i < LINES; i++) begin
         valid_m[0][i] = 1'b0;
         valid_m[1][i] = 1'b0;
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_m[i] = '0;
      end
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      assert (req_ready === 1'b1)
         else stop_with_error($sformatf("ERR t=%0t req_ready got %b exp 1", $time, req_ready));
      assert (rsp_valid === 1'b0)
         else stop_with_error($sformatf("ERR t=%0t rsp_valid got %b exp 0", $time, rsp_valid));

      // cold reads, second one held while the first misses
      send_req(OP_RD, make_addr(0, 8, 0), 16'h0);
      send_req(OP_RD, make_addr(5, 9, 1), 16'h0);
      idle(2);
      // write then read back, read should hit
      send_req(OP_WR, make_addr(2, 2, 1), 16'hA5C3);
      idle(1);
      send_req(OP_RD, make_addr(2, 2, 1), 16'h0);
      idle(3);
      // three tags fighting over two ways
      for (int k = 0; k < 6; k++) begin
         send_req(OP_RD, make_addr(1 + k % 3, 5, k % 4), 16'h0);
      end
      // dirty lines pushed out, then read again
      for (int t = 4; t < 8; t++) begin
         send_req(OP_WR, make_addr(t, 9, t % 3 + 1), 16'h1000 + 16'(t));
         send_req(OP_WR, make_addr(t, 9, 0), 16'h2000 + 16'(t));
      end
      for (int t = 4; t < 8; t++) begin
         send_req(OP_RD, make_addr(t, 9, t % 3 + 1), 16'h0);
         send_req(OP_RD, make_addr(t, 9, 0), 16'h0);
      end
      // odd addresses in between must not disturb the line
      send_req(OP_WR, make_addr(3, 12, 2), 16'h5A5A);
      send_req(OP_RD, make_addr(3, 12, 2) | 16'h0001, 16'h0);
      send_req(OP_WR, make_addr(3, 12, 2) | 16'h0001, 16'hDEAD);
      send_req(OP_RD, make_addr(3, 12, 2), 16'h0);
      idle(2);

      // random traffic on 4 tags x 4 indexes, gap 0 keeps req_valid up through the miss
      for (int n = 0; n < N_RAND; n++) begin
         rnd = $random(seed);
         send_req(op_e'(rnd[0]),
                  make_addr(int'(rnd[2:1]), int'(rnd[4:3]), int'(rnd[6:5])),
                  rnd[31:16]);
         if (rnd[8:7] != 2'd0) begin
            idle(int'(rnd[8:7]));
         end
      end
      idle(0);

      // bounded drain, then a few cycles to catch stray responses
      for (int k = 0; k < 100 && exp_q.size() != 0; k++) begin
         @(posedge clk);
      end
      repeat (8) @(posedge clk);
      if (exp_q.size() == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         stop_with_error($sformatf("%0d responses never arrived", exp_q.size()));
      end
   end

   // roughly 40 cycles per request covers a dirty miss with stalls
   initial begin
      #((N_REQ * 40 + 16) * CLK_PERIOD);
      stop_with_error("watchdog expired before all requests completed");
   end

endmodule

// ==== mem_system.f ====
cache_pkg.sv
cache_way.sv
way_select.sv
banked_mem.sv
cache_ctrl.sv
mem_system.sv
mem_system_chk.sv
mem_system_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = mem_system_tb
FILELIST  = mem_system.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failures found
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation FAILED, no verdict"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
